//--- hw/cpu_pkg.sv
package cpu_pkg;

    // fetch adds four on the first cycle, so boot starts at 0x1c00_0000
    localparam logic [31:0] reset_pc = 32'h1bff_fffc;

    // radix-16 steps for a 32-bit multiplier operand
    localparam int mul_steps = 8;

    typedef enum logic [3:0] {
        op_add,
        op_sub,
        op_addi,
        op_lu12i,
        op_mul,
        op_beq,
        op_bne,
        op_b,
        op_nop
    } op_e;

    // fetch to decode
    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] inst;
    } if_to_id_t;

    // decode to execute, operands already resolved
    typedef struct packed {
        logic [31:0] pc;
        op_e         op;
        logic [31:0] src_a;
        logic [31:0] src_b;
        logic [4:0]  dest;
        logic        wen;
    } id_to_ex_t;

    // retirement trace
    typedef struct packed {
        logic [31:0] pc;
        logic        wen;
        logic [4:0]  wnum;
        logic [31:0] wdata;
    } trace_t;

endpackage

//--- hw/fetch_stage.sv
`timescale 1ns/1ns

module fetch_stage (
    input  logic                clk,
    input  logic                resetn,
    output logic                inst_sram_en,
    output logic [31:0]         inst_sram_addr,
    input  logic [31:0]         inst_sram_rdata,
    input  logic                ds_allowin,
    input  logic                br_taken,
    input  logic [31:0]         br_target,
    output logic                fs_to_ds_valid,
    output cpu_pkg::if_to_id_t  fs_to_ds
);

    logic        fs_valid;
    logic        fs_allowin;
    logic [31:0] fs_pc;
    logic [31:0] seq_pc;
    logic [31:0] next_pc;
    logic [31:0] inst_buf;
    logic        inst_buf_valid;

    // single-cycle stage, ready_go is always high
    assign fs_allowin     = !fs_valid || ds_allowin;
    assign fs_to_ds_valid = fs_valid;

    assign seq_pc  = fs_pc + 32'd4;
    assign next_pc = br_taken ? br_target : seq_pc;

    // read the next pc only when a new instruction can be taken
    assign inst_sram_en   = fs_allowin && resetn;
    assign inst_sram_addr = next_pc;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            fs_valid <= 1'b0;
            fs_pc    <= cpu_pkg::reset_pc;
        end else if (fs_allowin) begin
            fs_valid <= 1'b1;
            fs_pc    <= next_pc;
        end
    end

    // keep the returned word while decode stalls,
    // the sram output is only good for one cycle
    always_ff @(posedge clk) begin
        if (!resetn) begin
            inst_buf_valid <= 1'b0;
        end else if (fs_allowin) begin
            inst_buf_valid <= 1'b0;
        end else if (!inst_buf_valid) begin
            inst_buf_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!fs_allowin && !inst_buf_valid) begin
            inst_buf <= inst_sram_rdata;
        end
    end

    assign fs_to_ds.pc   = fs_pc;
    assign fs_to_ds.inst = inst_buf_valid ? inst_buf : inst_sram_rdata;

endmodule

//--- hw/reg_file.sv
`timescale 1ns/1ns

module reg_file (
    input  logic        clk,
    input  logic [4:0]  raddr1,
    input  logic [4:0]  raddr2,
    output logic [31:0] rdata1,
    output logic [31:0] rdata2,
    input  logic        we,
    input  logic [4:0]  waddr,
    input  logic [31:0] wdata
);

    logic [31:0] regs [31:0];

    // r0 is never written
    always_ff @(posedge clk) begin
        if (we && waddr != 5'd0) begin
            regs[waddr] <= wdata;
        end
    end

    // asynchronous read with r0 forced to zero
    assign rdata1 = (raddr1 == 5'd0) ? 32'd0 : regs[raddr1];
    assign rdata2 = (raddr2 == 5'd0) ? 32'd0 : regs[raddr2];

    // a written register reads back the next cycle and r0 keeps reading zero
    read_after_write_a: assert property (
        @(posedge clk) we |=>
            (raddr1 != $past(waddr)
                || rdata1 == ($past(waddr) == 5'd0 ? 32'd0 : $past(wdata)))
            && (raddr2 != $past(waddr)
                || rdata2 == ($past(waddr) == 5'd0 ? 32'd0 : $past(wdata)))
    ) else $error("register read after write mismatch: rdata1=%h rdata2=%h", rdata1, rdata2);

endmodule

//--- hw/decode_stage.sv
`timescale 1ns/1ns

module decode_stage (
    input  logic                clk,
    input  logic                resetn,
    input  logic                fs_to_ds_valid,
    input  cpu_pkg::if_to_id_t  fs_to_ds,
    output logic                ds_allowin,
    output logic                br_taken,
    output logic [31:0]         br_target,
    output logic                ds_to_es_valid,
    output cpu_pkg::id_to_ex_t  ds_to_es,
    input  logic                es_allowin,
    input  logic                es_fwd_valid,
    input  logic [4:0]          es_fwd_num,
    input  logic [31:0]         es_fwd_data,
    input  logic                rf_we,
    input  logic [4:0]          rf_waddr,
    input  logic [31:0]         rf_wdata
);

    cpu_pkg::if_to_id_t ds_r;
    cpu_pkg::op_e       op;
    logic               ds_valid_r;
    logic               ds_cancel;
    logic               ds_valid;
    logic [31:0]        inst;
    logic [4:0]         rd;
    logic [4:0]         rj;
    logic [4:0]         rk;
    logic [4:0]         raddr1;
    logic [4:0]         raddr2;
    logic [31:0]        rdata1;
    logic [31:0]        rdata2;
    logic [31:0]        rj_value;
    logic [31:0]        rkd_value;
    logic [31:0]        br_offs;
    logic               br_cond;

    // a cancelled slot counts as empty
    assign ds_valid       = ds_valid_r && !ds_cancel;
    assign ds_allowin     = !ds_valid || es_allowin;
    assign ds_to_es_valid = ds_valid;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            ds_valid_r <= 1'b0;
            ds_cancel  <= 1'b0;
        end else if (ds_allowin) begin
            ds_valid_r <= fs_to_ds_valid;
            // the word arriving with a taken branch's handover is wrong-path
            ds_cancel  <= br_taken;
        end
    end

    always_ff @(posedge clk) begin
        if (fs_to_ds_valid && ds_allowin) begin
            ds_r <= fs_to_ds;
        end
    end

    assign inst = ds_r.inst;
    assign rd   = inst[4:0];
    assign rj   = inst[9:5];
    assign rk   = inst[14:10];

    always_comb begin
        op = cpu_pkg::op_nop;
        if (inst[31:15] == 17'h00020) begin
            op = cpu_pkg::op_add;
        end else if (inst[31:15] == 17'h00022) begin
            op = cpu_pkg::op_sub;
        end else if (inst[31:15] == 17'h00038) begin
            op = cpu_pkg::op_mul;
        end else if (inst[31:22] == 10'h00a) begin
            op = cpu_pkg::op_addi;
        end else if (inst[31:25] == 7'h0a) begin
            op = cpu_pkg::op_lu12i;
        end else if (inst[31:26] == 6'h16) begin
            op = cpu_pkg::op_beq;
        end else if (inst[31:26] == 6'h17) begin
            op = cpu_pkg::op_bne;
        end else if (inst[31:26] == 6'h14) begin
            op = cpu_pkg::op_b;
        end
    end

    // conditional branches compare rj against rd
    assign raddr1 = rj;
    assign raddr2 = (op == cpu_pkg::op_beq || op == cpu_pkg::op_bne) ? rd : rk;

    reg_file reg_file_i (
        .clk    (clk),
        .raddr1 (raddr1),
        .raddr2 (raddr2),
        .rdata1 (rdata1),
        .rdata2 (rdata2),
        .we     (rf_we),
        .waddr  (rf_waddr),
        .wdata  (rf_wdata)
    );

    // bypass from a finished execute result
    assign rj_value = (es_fwd_valid && es_fwd_num == raddr1 && raddr1 != 5'd0)
                    ? es_fwd_data : rdata1;
    assign rkd_value = (es_fwd_valid && es_fwd_num == raddr2 && raddr2 != 5'd0)
                     ? es_fwd_data : rdata2;

    assign br_cond = (op == cpu_pkg::op_beq && rj_value == rkd_value)
                  || (op == cpu_pkg::op_bne && rj_value != rkd_value)
                  || (op == cpu_pkg::op_b);
    assign br_taken = ds_valid && br_cond;

    // offs26 is split, high ten bits sit at the bottom
    assign br_offs = (op == cpu_pkg::op_b)
                   ? {{4{inst[9]}}, inst[9:0], inst[25:10], 2'b00}
                   : {{14{inst[25]}}, inst[25:10], 2'b00};
    assign br_target = ds_r.pc + br_offs;

    assign ds_to_es.pc    = ds_r.pc;
    assign ds_to_es.op    = op;
    assign ds_to_es.src_a = (op == cpu_pkg::op_lu12i) ? 32'd0 : rj_value;
    assign ds_to_es.src_b = (op == cpu_pkg::op_addi)  ? {{20{inst[21]}}, inst[21:10]}
                          : (op == cpu_pkg::op_lu12i) ? {inst[24:5], 12'd0}
                          : rkd_value;
    assign ds_to_es.dest  = rd;
    assign ds_to_es.wen   = (op == cpu_pkg::op_add) || (op == cpu_pkg::op_sub)
                         || (op == cpu_pkg::op_addi) || (op == cpu_pkg::op_lu12i)
                         || (op == cpu_pkg::op_mul);

    // the slot behind a taken branch is cancelled, so it can never branch
    no_branch_from_cancelled_a: assert property (
        @(posedge clk) disable iff (!resetn)
        (br_taken && es_allowin) |=> !br_taken
    ) else $error("br_taken from wrong-path slot, pc=%h", ds_r.pc);

endmodule

//--- hw/exec_stage.sv
`timescale 1ns/1ns

module exec_stage (
    input  logic                clk,
    input  logic                resetn,
    input  logic                ds_to_es_valid,
    input  cpu_pkg::id_to_ex_t  ds_to_es,
    output logic                es_allowin,
    output logic                es_fwd_valid,
    output logic [4:0]          es_fwd_num,
    output logic [31:0]         es_fwd_data,
    output logic                rf_we,
    output logic [4:0]          rf_waddr,
    output logic [31:0]         rf_wdata,
    output logic                trace_valid,
    output cpu_pkg::trace_t     trace
);

    typedef enum logic {
        st_idle,
        st_mul
    } state_e;

    state_e                                  state;
    cpu_pkg::id_to_ex_t                      es_r;
    logic                                    es_valid;
    logic                                    es_ready_go;
    logic                                    es_load;
    logic [31:0]                             alu_result;
    logic [31:0]                             es_result;
    logic [31:0]                             mul_acc;
    logic [31:0]                             mul_mcand;
    logic [31:0]                             mul_mplier;
    logic [$clog2(cpu_pkg::mul_steps)-1:0]   mul_cnt;

    // a multiply is done once the FSM drops back to idle
    assign es_ready_go = (state == st_idle);
    assign es_allowin  = !es_valid || es_ready_go;
    assign es_load     = ds_to_es_valid && es_allowin;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            es_valid <= 1'b0;
        end else if (es_allowin) begin
            es_valid <= ds_to_es_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (es_load) begin
            es_r <= ds_to_es;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state <= st_idle;
        end else begin
            case (state)
                st_idle: begin
                    if (es_load && ds_to_es.op == cpu_pkg::op_mul) begin
                        state <= st_mul;
                    end
                end
                st_mul: begin
                    if (mul_cnt == ($bits(mul_cnt))'(cpu_pkg::mul_steps - 1)) begin
                        state <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // radix-16 steps that keep only the low word
    always_ff @(posedge clk) begin
        if (es_load && ds_to_es.op == cpu_pkg::op_mul) begin
            mul_acc    <= 32'd0;
            mul_mcand  <= ds_to_es.src_a;
            mul_mplier <= ds_to_es.src_b;
            mul_cnt    <= '0;
        end else if (state == st_mul) begin
            mul_acc    <= mul_acc + mul_mcand * {28'd0, mul_mplier[3:0]};
            mul_mcand  <= mul_mcand << 4;
            mul_mplier <= mul_mplier >> 4;
            mul_cnt    <= mul_cnt + 1'b1;
        end
    end

    always_comb begin
        case (es_r.op)
            cpu_pkg::op_add:   alu_result = es_r.src_a + es_r.src_b;
            cpu_pkg::op_addi:  alu_result = es_r.src_a + es_r.src_b;
            cpu_pkg::op_sub:   alu_result = es_r.src_a - es_r.src_b;
            cpu_pkg::op_lu12i: alu_result = es_r.src_b;
            default:           alu_result = 32'd0;
        endcase
    end

    assign es_result = (es_r.op == cpu_pkg::op_mul) ? mul_acc : alu_result;

    // branches and nops retire with wen low
    assign trace_valid = es_valid && es_ready_go;
    assign rf_we       = trace_valid && es_r.wen;
    assign rf_waddr    = es_r.dest;
    assign rf_wdata    = es_result;

    assign es_fwd_valid = rf_we;
    assign es_fwd_num   = es_r.dest;
    assign es_fwd_data  = es_result;

    assign trace.pc    = es_r.pc;
    assign trace.wen   = es_r.wen;
    assign trace.wnum  = es_r.dest;
    assign trace.wdata = es_result;

    // decode is held back through every step of a multiply
    mul_blocks_allowin_a: assert property (
        @(posedge clk) disable iff (!resetn)
        (trace_valid && es_r.op == cpu_pkg::op_mul)
            |-> ($past(!es_allowin) && $past(!es_allowin, cpu_pkg::mul_steps))
    ) else $error("multiply retired without a full stall, pc=%h", es_r.pc);

    // only ops with a destination write the register file
    we_implies_trace_a: assert property (
        @(posedge clk) disable iff (!resetn)
        rf_we |-> (trace_valid && es_r.op inside {cpu_pkg::op_add, cpu_pkg::op_sub,
            cpu_pkg::op_addi, cpu_pkg::op_lu12i, cpu_pkg::op_mul})
    ) else $error("rf_we for a non-writing op, pc=%h op=%h", es_r.pc, es_r.op);

endmodule

//--- hw/cpu_core_top.sv
`timescale 1ns/1ns

module cpu_core_top (
    input  logic             clk,
    input  logic             resetn,
    output logic             inst_sram_en,
    output logic [31:0]      inst_sram_addr,
    input  logic [31:0]      inst_sram_rdata,
    output logic             trace_valid,
    output cpu_pkg::trace_t  trace
);

    cpu_pkg::if_to_id_t fs_to_ds;
    cpu_pkg::id_to_ex_t ds_to_es;
    logic               fs_to_ds_valid;
    logic               ds_allowin;
    logic               br_taken;
    logic [31:0]        br_target;
    logic               ds_to_es_valid;
    logic               es_allowin;
    logic               es_fwd_valid;
    logic [4:0]         es_fwd_num;
    logic [31:0]        es_fwd_data;
    logic               rf_we;
    logic [4:0]         rf_waddr;
    logic [31:0]        rf_wdata;

    fetch_stage fetch_stage_i (
        .clk             (clk),
        .resetn          (resetn),
        .inst_sram_en    (inst_sram_en),
        .inst_sram_addr  (inst_sram_addr),
        .inst_sram_rdata (inst_sram_rdata),
        .ds_allowin      (ds_allowin),
        .br_taken        (br_taken),
        .br_target       (br_target),
        .fs_to_ds_valid  (fs_to_ds_valid),
        .fs_to_ds        (fs_to_ds)
    );

    // register file lives inside decode, written back from execute
    decode_stage decode_stage_i (
        .clk            (clk),
        .resetn         (resetn),
        .fs_to_ds_valid (fs_to_ds_valid),
        .fs_to_ds       (fs_to_ds),
        .ds_allowin     (ds_allowin),
        .br_taken       (br_taken),
        .br_target      (br_target),
        .ds_to_es_valid (ds_to_es_valid),
        .ds_to_es       (ds_to_es),
        .es_allowin     (es_allowin),
        .es_fwd_valid   (es_fwd_valid),
        .es_fwd_num     (es_fwd_num),
        .es_fwd_data    (es_fwd_data),
        .rf_we          (rf_we),
        .rf_waddr       (rf_waddr),
        .rf_wdata       (rf_wdata)
    );

    exec_stage exec_stage_i (
        .clk            (clk),
        .resetn         (resetn),
        .ds_to_es_valid (ds_to_es_valid),
        .ds_to_es       (ds_to_es),
        .es_allowin     (es_allowin),
        .es_fwd_valid   (es_fwd_valid),
        .es_fwd_num     (es_fwd_num),
        .es_fwd_data    (es_fwd_data),
        .rf_we          (rf_we),
        .rf_waddr       (rf_waddr),
        .rf_wdata       (rf_wdata),
        .trace_valid    (trace_valid),
        .trace          (trace)
    );

endmodule

//--- verification/inst_rom_model.sv
`timescale 1ns/1ns

module inst_rom_model (
    input  logic        clk,
    input  logic        en,
    input  logic [31:0] addr,
    output logic [31:0] rdata
);

    // 1 KiB window at the boot address, loaded by the testbench
    logic [31:0] mem [0:255];
    logic [31:0] word;

    // unused words decode as nops and carry their own index
    initial begin
        rdata = 32'd0;
        for (int i = 0; i < 256; i++) begin
            mem[8'(i)] = {6'h3f, 26'(i)};
        end
    end

    // synchronous read, data shows up shortly after the edge
    always @(posedge clk) begin
        if (en) begin
            if (addr[31:10] == 22'h07_0000) begin
                word = mem[addr[9:2]];
            end else begin
                // outside the window, still a nop tied to the address
                word = {6'h3f, addr[27:2]};
            end
            #2;
            rdata = word;
        end
    end

endmodule

//--- verification/cpu_core_tb.sv
`timescale 1ns/1ns

module cpu_core_tb;

    logic            clk;
    logic            resetn;
    logic            inst_sram_en;
    logic [31:0]     inst_sram_addr;
    logic [31:0]     inst_sram_rdata;
    logic            trace_valid;
    cpu_pkg::trace_t trace;

    logic [31:0] prog[$];
    int          prog_sec[$];
    logic [31:0] exp_pc[$];
    logic        exp_wen[$];
    logic [4:0]  exp_wnum[$];
    logic [31:0] exp_wdata[$];
    int          exp_sec[$];
    int          exp_count = 0;
    int          exp_idx = 0;
    int          cur_sec = 1;
    int          cycle = 0;
    int          err_count [0:7];
    logic        boot_seen = 1'b0;
    logic        built = 1'b0;
    integer      seed = 32'h097e_2fc7;

    cpu_core_top cpu_core_top_i (
        .clk             (clk),
        .resetn          (resetn),
        .inst_sram_en    (inst_sram_en),
        .inst_sram_addr  (inst_sram_addr),
        .inst_sram_rdata (inst_sram_rdata),
        .trace_valid     (trace_valid),
        .trace           (trace)
    );

    inst_rom_model inst_rom_i (
        .clk   (clk),
        .en    (inst_sram_en),
        .addr  (inst_sram_addr),
        .rdata (inst_sram_rdata)
    );

    // LoongArch encodings, branch offsets in words
    function automatic logic [31:0] add_w(input logic [4:0] rd, rj, rk);
        return {17'h00020, rk, rj, rd};
    endfunction
    function automatic logic [31:0] sub_w(input logic [4:0] rd, rj, rk);
        return {17'h00022, rk, rj, rd};
    endfunction
    function automatic logic [31:0] mul_w(input logic [4:0] rd, rj, rk);
        return {17'h00038, rk, rj, rd};
    endfunction
    function automatic logic [31:0] addi_w(input logic [4:0] rd, rj, input logic [11:0] si);
        return {10'h00a, si, rj, rd};
    endfunction
    function automatic logic [31:0] lu12i_w(input logic [4:0] rd, input logic [19:0] si);
        return {7'h0a, si, rd};
    endfunction
    function automatic logic [31:0] beq_to(input logic [4:0] rj, rd, input logic [15:0] offs);
        return {6'h16, offs, rj, rd};
    endfunction
    function automatic logic [31:0] bne_to(input logic [4:0] rj, rd, input logic [15:0] offs);
        return {6'h17, offs, rj, rd};
    endfunction
    function automatic logic [31:0] b_to(input logic [25:0] offs);
        return {6'h14, offs[15:0], offs[25:16]};
    endfunction

    function automatic logic [4:0] pick_reg(input logic [31:0] r);
        return 5'(1 + r % 7);
    endfunction

    function automatic string test_name(input int k);
        case (k)
            1: return "reset and boot";
            2: return "alu results";
            3: return "forwarding";
            4: return "branches";
            5: return "multiply stall";
            default: return "register zero";
        endcase
    endfunction

    task automatic emit(input logic [31:0] word, input int sec);
        prog.push_back(word);
        prog_sec.push_back(sec);
    endtask

    task automatic count_error(input int sec);
        err_count[3'(sec)] = err_count[3'(sec)] + 1;
    endtask

    task automatic build_program;
        logic [31:0] r;
        logic [4:0]  rd;
        for (int i = 1; i < 8; i++) begin
            r = $random(seed);
            emit(lu12i_w(5'(i), r[19:0]), 2);
            r = $random(seed);
            emit(addi_w(5'(i), 5'(i), r[11:0]), 2);
        end
        // random mix over r1..r7
        for (int i = 0; i < 10; i++) begin
            r = $random(seed);
            rd = pick_reg(r >> 8);
            case (r[1:0])
                2'd0: emit(add_w(rd, pick_reg(r >> 16), pick_reg(r >> 24)), 2);
                2'd1: emit(sub_w(rd, pick_reg(r >> 16), pick_reg(r >> 24)), 2);
                2'd2: emit(addi_w(rd, pick_reg(r >> 16), r[31:20]), 2);
                default: emit(lu12i_w(rd, r[31:12]), 2);
            endcase
        end
        emit(addi_w(10, 0, 12'h123), 3);
        emit(addi_w(11, 10, 12'h7ff), 3);
        emit(add_w(12, 11, 10), 3);
        emit(sub_w(13, 12, 12), 3);
        emit(add_w(14, 13, 11), 3);
        emit(lu12i_w(15, 20'hfffff), 3);
        emit(add_w(15, 15, 15), 3);
        emit(addi_w(16, 0, 12'd5), 4);
        emit(addi_w(17, 0, 12'd5), 4);
        emit(addi_w(18, 0, 12'd9), 4);
        emit(beq_to(16, 17, 16'd2), 4);
        emit(addi_w(20, 0, 12'h111), 4);
        emit(bne_to(16, 18, 16'd2), 4);
        emit(addi_w(20, 0, 12'h222), 4);
        emit(b_to(26'd2), 4);
        emit(addi_w(20, 0, 12'h333), 4);
        emit(beq_to(16, 18, 16'd2), 4);
        emit(addi_w(21, 0, 12'd1), 4);
        emit(bne_to(16, 17, 16'd2), 4);
        emit(addi_w(22, 0, 12'd2), 4);
        emit(addi_w(23, 0, 12'd9), 4);
        emit(beq_to(23, 18, 16'd2), 4);
        emit(addi_w(20, 0, 12'h444), 4);
        emit(lu12i_w(24, 20'h12345), 5);
        emit(addi_w(24, 24, 12'h678), 5);
        emit(addi_w(25, 0, 12'hffd), 5);
        emit(mul_w(26, 24, 25), 5);
        emit(add_w(27, 26, 24), 5);
        emit(mul_w(28, 26, 26), 5);
        emit(addi_w(29, 28, 12'd1), 5);
        emit(add_w(0, 24, 25), 6);
        emit(add_w(9, 0, 24), 6);
        emit(addi_w(8, 0, 12'd7), 6);
        // park the core on a self loop
        emit(b_to(26'd0), 6);
    endtask

    // in-order architectural model, one entry per retired instruction
    task automatic run_model;
        logic [31:0] regs [0:31];
        logic [31:0] pc;
        logic [31:0] w;
        logic [31:0] a;
        logic [31:0] res;
        logic [31:0] next_pc;
        logic        wr;
        logic        done;
        int          idx;
        for (int i = 0; i < 32; i++) begin
            regs[5'(i)] = 32'd0;
        end
        pc = 32'h1c00_0000;
        done = 1'b0;
        for (int steps = 0; steps < 1024 && !done; steps++) begin
            idx = int'((pc - 32'h1c00_0000) >> 2);
            w = prog[idx];
            a = regs[w[9:5]];
            res = 32'd0;
            wr = 1'b1;
            next_pc = pc + 32'd4;
            if (w[31:15] == 17'h00020) begin
                res = a + regs[w[14:10]];
            end else if (w[31:15] == 17'h00022) begin
                res = a - regs[w[14:10]];
            end else if (w[31:15] == 17'h00038) begin
                res = a * regs[w[14:10]];
            end else if (w[31:22] == 10'h00a) begin
                res = a + {{20{w[21]}}, w[21:10]};
            end else if (w[31:25] == 7'h0a) begin
                res = {w[24:5], 12'h000};
            end else begin
                wr = 1'b0;
                if ((w[31:26] == 6'h16 && a == regs[w[4:0]])
                        || (w[31:26] == 6'h17 && a != regs[w[4:0]])) begin
                    next_pc = pc + {{14{w[25]}}, w[25:10], 2'b00};
                end else if (w[31:26] == 6'h14) begin
                    next_pc = pc + {{4{w[9]}}, w[9:0], w[25:10], 2'b00};
                    done = (next_pc == pc);
                end
            end
            exp_pc.push_back(pc);
            exp_wen.push_back(wr);
            exp_wnum.push_back(w[4:0]);
            exp_wdata.push_back(res);
            exp_sec.push_back(prog_sec[idx]);
            if (wr && w[4:0] != 5'd0) begin
                regs[w[4:0]] = res;
            end
            pc = next_pc;
        end
        exp_count = exp_pc.size();
    endtask

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial begin
        resetn = 1'b0;
        for (int i = 0; i < 8; i++) begin
            err_count[3'(i)] = 0;
        end
        build_program();
        run_model();
        #1;
        for (int i = 0; i < prog.size(); i++) begin
            inst_rom_i.mem[8'(i)] = prog[i];
        end
        built = 1'b1;
        repeat (3) @(posedge clk);
        #2;
        resetn = 1'b1;
    end

    // walks the expected trace, one entry per retirement beat
    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (resetn && inst_sram_en) begin
            boot_seen <= 1'b1;
        end
        if (resetn && trace_valid && exp_idx < exp_count) begin
            exp_idx <= exp_idx + 1;
            cur_sec <= (exp_idx + 1 < exp_count) ? exp_sec[exp_idx + 1] : 7;
        end
    end

    reset_quiet_a: assert property (
        @(posedge clk) (!resetn && cycle > 0) |-> (!trace_valid && !inst_sram_en)
    ) else begin
        $display("FAIL trace_valid=%h inst_sram_en=%h in reset, expected 0",
                 $sampled(trace_valid), $sampled(inst_sram_en));
        count_error(1);
    end

    boot_addr_a: assert property (
        @(posedge clk) (resetn && inst_sram_en && !boot_seen)
            |-> inst_sram_addr == 32'h1c00_0000
    ) else begin
        $display("FAIL inst_sram_addr expected 1c000000 got %h", $sampled(inst_sram_addr));
        count_error(1);
    end

    addr_hold_a: assert property (
        @(posedge clk) disable iff (!resetn)
        (!inst_sram_en && $past(!inst_sram_en)) |-> $stable(inst_sram_addr)
    ) else begin
        $display("FAIL inst_sram_addr moved to %h while inst_sram_en low",
                 $sampled(inst_sram_addr));
        count_error($sampled(cur_sec));
    end

    trace_pc_a: assert property (
        @(posedge clk) disable iff (!resetn)
        (trace_valid && exp_idx < exp_count)
            |-> (trace.pc == exp_pc[exp_idx] && trace.wen == exp_wen[exp_idx])
    ) else begin
        $display("FAIL trace.pc expected %h got %h, trace.wen expected %h got %h",
                 exp_pc[$sampled(exp_idx)], $sampled(trace.pc),
                 exp_wen[$sampled(exp_idx)], $sampled(trace.wen));
        count_error(exp_sec[$sampled(exp_idx)]);
    end

    trace_data_a: assert property (
        @(posedge clk) disable iff (!resetn)
        (trace_valid && exp_idx < exp_count && exp_wen[exp_idx])
            |-> (trace.wnum == exp_wnum[exp_idx] && trace.wdata == exp_wdata[exp_idx])
    ) else begin
        $display("FAIL trace.wnum expected %h got %h, trace.wdata expected %h got %h",
                 exp_wnum[$sampled(exp_idx)], $sampled(trace.wnum),
                 exp_wdata[$sampled(exp_idx)], $sampled(trace.wdata));
        count_error(exp_sec[$sampled(exp_idx)]);
    end

    // a test is over once the trace moves past its last entry
    initial begin : report
        int total;
        int failed;
        total = 0;
        failed = 0;
        wait (built);
        for (int k = 1; k < 7; k++) begin
            wait (cur_sec > k);
            #1;
            if (err_count[3'(k)] == 0) begin
                $display("test %0d %s: ok", k, test_name(k));
            end else begin
                $display("test %0d %s: %0d errors", k, test_name(k), err_count[3'(k)]);
                failed++;
            end
            total += err_count[3'(k)];
        end
        $display("6 tests, %0d passed, %0d failed, %0d errors", 6 - failed, failed, total);
        if (total == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    initial begin : watchdog
        int limit;
        wait (built);
        // twelve cycles per instruction covers the multiply stalls
        limit = prog.size() * 12 * 40 + 4000;
        #(limit);
        $display("timeout, %0d of %0d trace entries retired", exp_idx, exp_count);
        $display("sim failed");
        $finish;
    end

endmodule

//--- vlog.f
hw/cpu_pkg.sv
hw/fetch_stage.sv
hw/reg_file.sv
hw/decode_stage.sv
hw/exec_stage.sv
hw/cpu_core_top.sv
verification/inst_rom_model.sv
verification/cpu_core_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the core testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module cpu_core_tb \
    -f vlog.f \
    -o cpu_core_sim

./obj_dir/cpu_core_sim | tee sim.log

if grep -q "sim failed" sim.log; then
    exit 1
fi
if ! grep -q "sim passed" sim.log; then
    exit 1
fi
exit 0
